// ==== hmem_cfg_pkg.sv ====
// Hart-local L2 cache configuration
// Fixed address and line geometry, plus the word types that every
// block of the cache and its external bus share

package hmem_cfg_pkg;

    // Byte address width
    localparam int ADDR_W = 32;

    // Line geometry
    localparam int LINE_BYTES = 32;
    localparam int OFFS_W     = $clog2(LINE_BYTES);

    // Core word widths
    localparam int IWORD_W = 32;
    localparam int DWORD_W = 64;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [8*LINE_BYTES-1:0] line_t;
    typedef logic [IWORD_W-1:0]      iword_t;
    typedef logic [DWORD_W-1:0]      dword_t;
    typedef logic [OFFS_W-1:0]       offs_t;

endpackage

// ==== hmem_if_pkg.sv ====
// Hart-local L2 cache interface types
// Request structs on the core ports and the memory bus, the store
// fill record and the controller state encoding

package hmem_if_pkg;

    // Line-wide request towards external memory
    typedef struct packed {
        hmem_cfg_pkg::addr_t addr;
        hmem_cfg_pkg::line_t wline;
        logic                rd;
        logic                wr;
    } mem_req_t;

    // Data port request, whole aligned 64-bit words only
    typedef struct packed {
        hmem_cfg_pkg::addr_t  addr;
        hmem_cfg_pkg::dword_t wdata;
        logic                 rd;
        logic                 wr;
    } dport_req_t;

    // Instruction port request
    typedef struct packed {
        hmem_cfg_pkg::addr_t addr;
        logic                rd;
    } iport_req_t;

    // Tag and line RAM write, fields sized for the largest geometry
    typedef struct packed {
        logic [7:0]          set;
        logic [2:0]          way;
        hmem_cfg_pkg::addr_t tag;
        hmem_cfg_pkg::line_t line;
    } fill_t;

    typedef enum logic [2:0] {
        READY,
        FETCH_I,
        LOAD_I,
        FETCH_D,
        LOAD_D,
        WRITE
    } ctrl_state_e;

endpackage

// ==== hmem_tag_store.sv ====
// L2 cache tag store
// Holds tag and valid bit for every set and way, looks up both core
// ports in parallel and takes fills and single-line invalidates

module hmem_tag_store #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  hmem_cfg_pkg::addr_t         i_addr_i,
    input  hmem_cfg_pkg::addr_t         d_addr_i,
    input  hmem_if_pkg::fill_t          fill_i,
    input  logic                        fill_en_i,
    input  logic                        inv_i,
    input  hmem_cfg_pkg::addr_t         inv_addr_i,
    output logic                        i_hit_o,
    output logic [$clog2(WAYS)-1:0]     i_way_o,
    output logic                        d_hit_o,
    output logic [$clog2(WAYS)-1:0]     d_way_o
);
    import hmem_cfg_pkg::*;

    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int TAG_W = ADDR_W - OFFS_W - SET_W;

    logic [TAG_W-1:0] tag_q   [SETS][WAYS];
    logic [WAYS-1:0]  valid_q [SETS];

    addr_t            look_addr [2];
    logic [1:0]       look_hit;
    logic [WAY_W-1:0] look_way  [2];

    logic [SET_W-1:0] inv_set;
    logic [TAG_W-1:0] inv_tag;
    logic [SET_W-1:0] fill_set;
    logic [WAY_W-1:0] fill_way;

    assign look_addr[0] = i_addr_i;
    assign look_addr[1] = d_addr_i;

    // Both ports compare against all ways of their set at once
    always_comb begin
        logic [SET_W-1:0] s;
        for (int p = 0; p < 2; p++) begin
            s = look_addr[p][OFFS_W +: SET_W];
            look_hit[p] = 1'b0;
            look_way[p] = '0;
            for (int w = 0; w < WAYS; w++) begin
                if (valid_q[s][w] && tag_q[s][w] == look_addr[p][ADDR_W-1 -: TAG_W]) begin
                    look_hit[p] = 1'b1;
                    look_way[p] = WAY_W'(w);
                end
            end
        end
    end

    assign i_hit_o = look_hit[0];
    assign i_way_o = look_way[0];
    assign d_hit_o = look_hit[1];
    assign d_way_o = look_way[1];

    assign inv_set  = inv_addr_i[OFFS_W +: SET_W];
    assign inv_tag  = inv_addr_i[ADDR_W-1 -: TAG_W];
    assign fill_set = fill_i.set[SET_W-1:0];
    assign fill_way = fill_i.way[WAY_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            if (inv_i) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (tag_q[inv_set][w] == inv_tag) begin
                        valid_q[inv_set][w] <= 1'b0;
                    end
                end
            end
            if (fill_en_i) begin
                valid_q[fill_set][fill_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[fill_set][fill_way] <= fill_i.tag[TAG_W-1:0];
        end
    end

endmodule

// ==== hmem_plru.sv ====
// Tree pseudo-LRU replacement state
// One WAYS-1 bit tree per set; a node bit of 1 points to the left
// subtree as the next victim, 0 to the right one

module hmem_plru #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    touch_en_i,
    input  logic [$clog2(SETS)-1:0] touch_set_i,
    input  logic [$clog2(WAYS)-1:0] touch_way_i,
    input  logic [$clog2(SETS)-1:0] vic_set_i,
    output logic [$clog2(WAYS)-1:0] victim_o
);

    localparam int WAY_W = $clog2(WAYS);
    localparam int LVLS  = $clog2(WAYS);

    logic [WAYS-2:0] tree_q [SETS];

    // Walk from the leaf to the root, turning each node away from the way
    function automatic logic [WAYS-2:0] touch(input logic [WAYS-2:0] t,
                                              input logic [WAY_W-1:0] way);
        int node;
        int parent;
        node = int'(way) + WAYS - 1;
        for (int l = 0; l < LVLS; l++) begin
            parent = (node - 1) / 2;
            // Odd nodes are left children
            t[parent] = node[0] ? 1'b0 : 1'b1;
            node = parent;
        end
        return t;
    endfunction

    always_comb begin
        int node;
        node = 0;
        for (int l = 0; l < LVLS; l++) begin
            node = tree_q[vic_set_i][node] ? 2 * node + 1 : 2 * node + 2;
        end
        victim_o = WAY_W'(node - (WAYS - 1));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '1;
            end
        end else if (touch_en_i) begin
            tree_q[touch_set_i] <= touch(tree_q[touch_set_i], touch_way_i);
        end
    end

endmodule

// ==== hmem_data_store.sv ====
// L2 cache line RAM
// SETS x WAYS lines, one write port fed by fills and one registered
// read port per core port

module hmem_data_store #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    wr_en_i,
    input  hmem_if_pkg::fill_t      fill_i,
    input  logic                    i_rd_en_i,
    input  logic [$clog2(SETS)-1:0] i_set_i,
    input  logic [$clog2(WAYS)-1:0] i_way_i,
    output hmem_cfg_pkg::line_t     i_line_o,
    input  logic                    d_rd_en_i,
    input  logic [$clog2(SETS)-1:0] d_set_i,
    input  logic [$clog2(WAYS)-1:0] d_way_i,
    output hmem_cfg_pkg::line_t     d_line_o
);
    import hmem_cfg_pkg::*;

    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);

    // Both dimensions are powers of two, so set and way concatenate
    line_t mem_q [SETS*WAYS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[{fill_i.set[SET_W-1:0], fill_i.way[WAY_W-1:0]}] <= fill_i.line;
        end
        if (i_rd_en_i) begin
            i_line_o <= mem_q[{i_set_i, i_way_i}];
        end
        if (d_rd_en_i) begin
            d_line_o <= mem_q[{d_set_i, d_way_i}];
        end
    end

endmodule

// ==== hmem_line_buf.sv ====
// Per-port line buffer
// Holds one cache line with its set and tag, reports whether the
// requested address falls in it and picks the addressed word

module hmem_line_buf #(
    parameter int SETS = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ld_i,
    input  hmem_cfg_pkg::addr_t  ld_addr_i,
    input  hmem_cfg_pkg::line_t  ld_line_i,
    input  logic                 inv_i,
    input  hmem_cfg_pkg::addr_t  inv_addr_i,
    input  hmem_cfg_pkg::addr_t  req_addr_i,
    output logic                 match_o,
    output hmem_cfg_pkg::iword_t iword_o,
    output hmem_cfg_pkg::dword_t dword_o
);
    import hmem_cfg_pkg::*;

    localparam int SET_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFS_W - SET_W;

    logic             valid_q;
    logic [SET_W-1:0] set_q;
    logic [TAG_W-1:0] tag_q;
    line_t            line_q;

    assign match_o = valid_q && set_q == req_addr_i[OFFS_W +: SET_W]
                     && tag_q == req_addr_i[ADDR_W-1 -: TAG_W];

    // Data word by bits 4:3, instruction half by bit 2
    assign dword_o = line_q[DWORD_W*req_addr_i[OFFS_W-1:3] +: DWORD_W];
    assign iword_o = req_addr_i[2] ? dword_o[63:32] : dword_o[31:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (ld_i) begin
            valid_q <= 1'b1;
        end else if (inv_i && set_q == inv_addr_i[OFFS_W +: SET_W]
                     && tag_q == inv_addr_i[ADDR_W-1 -: TAG_W]) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_i) begin
            set_q  <= ld_addr_i[OFFS_W +: SET_W];
            tag_q  <= ld_addr_i[ADDR_W-1 -: TAG_W];
            line_q <= ld_line_i;
        end
    end

endmodule

// ==== hmem_ctrl.sv ====
// L2 cache controller
// Serves buffer misses by loading from the line RAM or fetching from
// memory, data port first, and runs write-through with allocate.
// Keeps a copy of the data buffer line as the base for word merges

module hmem_ctrl #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hmem_if_pkg::iport_req_t i_req_i,
    input  hmem_if_pkg::dport_req_t d_req_i,
    input  logic                    i_match_i,
    input  logic                    d_match_i,
    input  logic                    i_hit_i,
    input  logic [$clog2(WAYS)-1:0] i_way_i,
    input  logic                    d_hit_i,
    input  logic [$clog2(WAYS)-1:0] d_way_i,
    input  logic [$clog2(WAYS)-1:0] victim_i,
    input  hmem_cfg_pkg::line_t     d_line_i,
    input  hmem_cfg_pkg::line_t     mem_rdata_i,
    input  logic                    mem_dv_i,
    output hmem_if_pkg::fill_t      fill_o,
    output logic                    fill_en_o,
    output logic                    i_rd_en_o,
    output logic [$clog2(SETS)-1:0] i_rd_set_o,
    output logic [$clog2(WAYS)-1:0] i_rd_way_o,
    output logic                    d_rd_en_o,
    output logic [$clog2(SETS)-1:0] d_rd_set_o,
    output logic [$clog2(WAYS)-1:0] d_rd_way_o,
    output logic                    touch_en_o,
    output logic [$clog2(SETS)-1:0] touch_set_o,
    output logic [$clog2(WAYS)-1:0] touch_way_o,
    output logic [$clog2(SETS)-1:0] vic_set_o,
    output logic                    i_ld_o,
    output logic                    d_ld_o,
    output hmem_cfg_pkg::line_t     ld_line_o,
    output hmem_if_pkg::mem_req_t   mem_req_o,
    output logic                    stall_o,
    output logic                    inv_ok_o
);
    import hmem_cfg_pkg::*;
    import hmem_if_pkg::*;

    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    logic             wr_q;
    logic             wr_done_q;

    // Write buffer and merge base
    addr_t            addr_q;
    dword_t           wdata_q;
    logic [WAY_W-1:0] way_q;
    line_t            base_q;
    line_t            merged;

    logic             d_wr;
    logic             d_miss;
    logic             i_miss;
    logic             sel_d;
    addr_t            sel_addr;
    logic             sel_hit;
    logic [WAY_W-1:0] sel_way;

    // The cycle after WRITE acknowledges the write, so it is not restarted
    assign d_wr   = d_req_i.wr && !wr_done_q;
    assign d_miss = d_req_i.rd && !d_match_i;
    assign i_miss = i_req_i.rd && !i_match_i;

    assign sel_d    = d_wr || d_miss;
    assign sel_addr = sel_d ? d_req_i.addr : i_req_i.addr;
    assign sel_hit  = sel_d ? d_hit_i : i_hit_i;
    assign sel_way  = !sel_hit ? victim_i : (sel_d ? d_way_i : i_way_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            READY: begin
                if (d_wr) begin
                    state_d = d_match_i ? WRITE : (d_hit_i ? LOAD_D : FETCH_D);
                end else if (d_miss) begin
                    state_d = d_hit_i ? LOAD_D : FETCH_D;
                end else if (i_miss) begin
                    state_d = i_hit_i ? LOAD_I : FETCH_I;
                end
            end
            FETCH_I: if (mem_dv_i) state_d = READY;
            LOAD_I:  state_d = READY;
            FETCH_D: if (mem_dv_i) state_d = wr_q ? WRITE : READY;
            LOAD_D:  state_d = wr_q ? WRITE : READY;
            default: state_d = READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= READY;
            wr_q      <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            wr_done_q <= state_q == WRITE;
            if (state_q == READY && state_d != READY) begin
                wr_q <= d_wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == READY) begin
            addr_q  <= sel_addr;
            wdata_q <= d_req_i.wdata;
            way_q   <= sel_way;
        end
        // Mirror of whatever the data buffer takes
        if (d_ld_o) begin
            base_q <= ld_line_o;
        end
    end

    always_comb begin
        merged = base_q;
        merged[DWORD_W*addr_q[OFFS_W-1:3] +: DWORD_W] = wdata_q;
    end

    // RAM reads are issued in READY and seen during LOAD
    assign i_rd_en_o  = state_q == READY && state_d == LOAD_I;
    assign i_rd_set_o = i_req_i.addr[OFFS_W +: SET_W];
    assign i_rd_way_o = i_way_i;
    assign d_rd_en_o  = state_q == READY && state_d == LOAD_D;
    assign d_rd_set_o = d_req_i.addr[OFFS_W +: SET_W];
    assign d_rd_way_o = d_way_i;

    assign vic_set_o   = sel_addr[OFFS_W +: SET_W];
    assign touch_en_o  = state_q == READY && state_d != READY;
    assign touch_set_o = vic_set_o;
    assign touch_way_o = sel_way;

    assign fill_en_o   = ((state_q == FETCH_I || state_q == FETCH_D) && mem_dv_i)
                         || state_q == WRITE;
    assign fill_o.set  = 8'(addr_q[OFFS_W +: SET_W]);
    assign fill_o.way  = 3'(way_q);
    assign fill_o.tag  = addr_q >> (OFFS_W + SET_W);
    assign fill_o.line = state_q == WRITE ? merged : mem_rdata_i;

    assign i_ld_o = (state_q == FETCH_I && mem_dv_i) || state_q == LOAD_I;
    assign d_ld_o = (state_q == FETCH_D && mem_dv_i) || state_q == LOAD_D
                    || state_q == WRITE;

    always_comb begin
        case (state_q)
            WRITE:   ld_line_o = merged;
            LOAD_D:  ld_line_o = d_line_i;
            default: ld_line_o = mem_rdata_i;
        endcase
    end

    assign mem_req_o.addr  = {addr_q[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign mem_req_o.wline = merged;
    assign mem_req_o.rd    = state_q == FETCH_I || state_q == FETCH_D;
    assign mem_req_o.wr    = state_q == WRITE;

    assign stall_o  = state_q != READY || (!wr_done_q && (d_wr || d_miss || i_miss));
    assign inv_ok_o = state_q == READY;

endmodule

// ==== hmem_top.sv ====
// Hart-local L2 cache top level
// Joins controller, tag store, PLRU, line RAM and the two port
// buffers to the core ports and the line-wide memory bus

module hmem_top #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hmem_if_pkg::iport_req_t i_req_i,
    output hmem_cfg_pkg::iword_t    i_rdata_o,
    output logic                    i_dv_o,
    input  hmem_if_pkg::dport_req_t d_req_i,
    output hmem_cfg_pkg::dword_t    d_rdata_o,
    output logic                    d_dv_o,
    output logic                    stall_o,
    input  logic                    inv_i,
    input  hmem_cfg_pkg::addr_t     inv_addr_i,
    output hmem_if_pkg::mem_req_t   mem_req_o,
    input  hmem_cfg_pkg::line_t     mem_rdata_i,
    input  logic                    mem_dv_i
);
    import hmem_cfg_pkg::*;
    import hmem_if_pkg::*;

    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);

    fill_t            fill;
    logic             fill_en;
    logic             i_match;
    logic             d_match;
    logic             i_hit;
    logic             d_hit;
    logic [WAY_W-1:0] i_way;
    logic [WAY_W-1:0] d_way;
    logic [WAY_W-1:0] victim;
    logic             i_rd_en;
    logic [SET_W-1:0] i_rd_set;
    logic [WAY_W-1:0] i_rd_way;
    logic             d_rd_en;
    logic [SET_W-1:0] d_rd_set;
    logic [WAY_W-1:0] d_rd_way;
    logic             touch_en;
    logic [SET_W-1:0] touch_set;
    logic [WAY_W-1:0] touch_way;
    logic [SET_W-1:0] vic_set;
    logic             i_ld;
    logic             d_ld;
    line_t            ld_line;
    line_t            i_line;
    line_t            d_line;
    line_t            i_ld_line;
    logic             inv_ok;
    logic             inv_en;

    assign inv_en = inv_i && inv_ok;
    assign i_dv_o = i_match && i_req_i.rd;
    assign d_dv_o = d_match && d_req_i.rd;

    // Memory line while fetching, RAM line in LOAD_I
    assign i_ld_line = mem_req_o.rd ? ld_line : i_line;

    hmem_ctrl #(.SETS(SETS), .WAYS(WAYS)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .i_req_i(i_req_i), .d_req_i(d_req_i),
        .i_match_i(i_match), .d_match_i(d_match),
        .i_hit_i(i_hit), .i_way_i(i_way), .d_hit_i(d_hit), .d_way_i(d_way),
        .victim_i(victim), .d_line_i(d_line),
        .mem_rdata_i(mem_rdata_i), .mem_dv_i(mem_dv_i),
        .fill_o(fill), .fill_en_o(fill_en),
        .i_rd_en_o(i_rd_en), .i_rd_set_o(i_rd_set), .i_rd_way_o(i_rd_way),
        .d_rd_en_o(d_rd_en), .d_rd_set_o(d_rd_set), .d_rd_way_o(d_rd_way),
        .touch_en_o(touch_en), .touch_set_o(touch_set), .touch_way_o(touch_way),
        .vic_set_o(vic_set), .i_ld_o(i_ld), .d_ld_o(d_ld), .ld_line_o(ld_line),
        .mem_req_o(mem_req_o), .stall_o(stall_o), .inv_ok_o(inv_ok)
    );

    hmem_tag_store #(.SETS(SETS), .WAYS(WAYS)) u_tags (
        .clk(clk), .rst_n(rst_n),
        .i_addr_i(i_req_i.addr), .d_addr_i(d_req_i.addr),
        .fill_i(fill), .fill_en_i(fill_en),
        .inv_i(inv_en), .inv_addr_i(inv_addr_i),
        .i_hit_o(i_hit), .i_way_o(i_way), .d_hit_o(d_hit), .d_way_o(d_way)
    );

    hmem_plru #(.SETS(SETS), .WAYS(WAYS)) u_plru (
        .clk(clk), .rst_n(rst_n),
        .touch_en_i(touch_en), .touch_set_i(touch_set), .touch_way_i(touch_way),
        .vic_set_i(vic_set), .victim_o(victim)
    );

    hmem_data_store #(.SETS(SETS), .WAYS(WAYS)) u_data (
        .clk(clk), .wr_en_i(fill_en), .fill_i(fill),
        .i_rd_en_i(i_rd_en), .i_set_i(i_rd_set), .i_way_i(i_rd_way), .i_line_o(i_line),
        .d_rd_en_i(d_rd_en), .d_set_i(d_rd_set), .d_way_i(d_rd_way), .d_line_o(d_line)
    );

    hmem_line_buf #(.SETS(SETS)) u_ibuf (
        .clk(clk), .rst_n(rst_n),
        .ld_i(i_ld), .ld_addr_i(i_req_i.addr), .ld_line_i(i_ld_line),
        .inv_i(inv_en), .inv_addr_i(inv_addr_i), .req_addr_i(i_req_i.addr),
        .match_o(i_match), .iword_o(i_rdata_o), .dword_o()
    );

    hmem_line_buf #(.SETS(SETS)) u_dbuf (
        .clk(clk), .rst_n(rst_n),
        .ld_i(d_ld), .ld_addr_i(d_req_i.addr), .ld_line_i(ld_line),
        .inv_i(inv_en), .inv_addr_i(inv_addr_i), .req_addr_i(d_req_i.addr),
        .match_o(d_match), .iword_o(), .dword_o(d_rdata_o)
    );

endmodule

// ==== hmem_props.sv ====
// L2 cache bus and port properties
// Concurrent checks on the external memory request and on data valid
// at the two core ports, bound into the cache top level

module hmem_props (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hmem_if_pkg::mem_req_t   mem_req_i,
    input  hmem_if_pkg::iport_req_t i_req_i,
    input  hmem_if_pkg::dport_req_t d_req_i,
    input  logic                    i_dv_i,
    input  logic                    d_dv_i,
    input  logic                    stall_i
);

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req_i.rd && mem_req_i.wr))
        else $error("memory read and write requested in the same cycle");

    // Memory takes the write line in the one cycle it is shown
    wr_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_i.wr |=> !mem_req_i.wr)
        else $error("memory write held for more than one cycle");

    // A stalled request ends with the address it was stalled on
    i_dv_same_addr: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i && i_req_i.rd ##1 i_dv_i |-> $stable(i_req_i.addr))
        else $error("instruction data valid with a changed address");

    d_dv_same_addr: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i && d_req_i.rd ##1 d_dv_i |-> $stable(d_req_i.addr))
        else $error("data valid with a changed address");

endmodule

bind hmem_top hmem_props u_props (
    .clk(clk), .rst_n(rst_n), .mem_req_i(mem_req_o),
    .i_req_i(i_req_i), .d_req_i(d_req_i),
    .i_dv_i(i_dv_o), .d_dv_i(d_dv_o), .stall_i(stall_o)
);

// ==== tb_hmem.sv ====
// Directed testbench for the hart-local L2 cache
// Behavioural line memory with random response delay, one task per
// behaviour, typed compare tasks and a closing summary

module tb_hmem;
    import hmem_cfg_pkg::*;
    import hmem_if_pkg::*;

    localparam int MEM_LINES = 1024;
    localparam int WAIT_MAX  = 50;

    logic       clk;
    logic       rst_n;
    iport_req_t i_req;
    dport_req_t d_req;
    iword_t     i_rdata;
    dword_t     d_rdata;
    logic       i_dv_o;
    logic       d_dv_o;
    logic       stall_o;
    logic       inv_i;
    addr_t      inv_addr_i;
    mem_req_t   mem_req_o;
    line_t      mem_rdata_i = '0;
    logic       mem_dv_i = 1'b0;

    // Behavioural memory and its bookkeeping
    line_t  mem_line [MEM_LINES];
    line_t  last_wline;
    integer seed = 31378;
    int     rd_count = 0;
    int     wr_count = 0;
    logic   rd_busy = 1'b0;
    int     rd_wait = 0;
    int     checks = 0;
    int     errors = 0;

    hmem_top #(.SETS(16), .WAYS(4)) UUT (
        .clk(clk), .rst_n(rst_n),
        .i_req_i(i_req), .i_rdata_o(i_rdata), .i_dv_o(i_dv_o),
        .d_req_i(d_req), .d_rdata_o(d_rdata), .d_dv_o(d_dv_o),
        .stall_o(stall_o), .inv_i(inv_i), .inv_addr_i(inv_addr_i),
        .mem_req_o(mem_req_o), .mem_rdata_i(mem_rdata_i), .mem_dv_i(mem_dv_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int line_idx(input addr_t a);
        return int'(a[14:5]);
    endfunction

    // Little-endian words of the memory line
    function automatic iword_t instr_at(input addr_t a);
        return mem_line[line_idx(a)][32*a[4:2] +: 32];
    endfunction

    function automatic dword_t data_at(input addr_t a);
        return mem_line[line_idx(a)][64*a[4:3] +: 64];
    endfunction

    // Reads answer after 1 to 6 cycles, writes land at once
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_dv_i <= 1'b0;
            rd_busy = 1'b0;
        end else begin
            mem_dv_i <= 1'b0;
            if (mem_req_o.wr) begin
                mem_line[line_idx(mem_req_o.addr)] = mem_req_o.wline;
                last_wline = mem_req_o.wline;
                wr_count++;
            end
            if (mem_req_o.rd && !mem_dv_i) begin
                if (!rd_busy) begin
                    rd_busy = 1'b1;
                    rd_wait = 1 + $unsigned($random(seed)) % 6;
                end
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_dv_i    <= 1'b1;
                    mem_rdata_i <= mem_line[line_idx(mem_req_o.addr)];
                    rd_busy = 1'b0;
                    rd_count++;
                end
            end
        end
    end

    task automatic check_iword(input string name, input iword_t got, input iword_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - err0);
        end
    endtask

    // Latency counts cycles after the request cycle
    task automatic fetch_instr(input addr_t a, output iword_t w, output int lat);
        int n;
        @(posedge clk);
        i_req.addr <= a;
        i_req.rd   <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!i_dv_o) begin
            n++;
            if (n > WAIT_MAX) abort_run("instruction data valid");
            @(negedge clk);
        end
        w = i_rdata;
        lat = n;
        @(posedge clk);
        i_req <= '0;
    endtask

    task automatic load_dword(input addr_t a, output dword_t w, output int lat);
        int n;
        @(posedge clk);
        d_req.addr <= a;
        d_req.rd   <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!d_dv_o) begin
            n++;
            if (n > WAIT_MAX) abort_run("data valid");
            @(negedge clk);
        end
        w = d_rdata;
        lat = n;
        @(posedge clk);
        d_req <= '0;
    endtask

    // Returns the number of cycles the write was stalled
    task automatic store_dword(input addr_t a, input dword_t data, output int lat);
        int n;
        @(posedge clk);
        d_req.addr  <= a;
        d_req.wdata <= data;
        d_req.wr    <= 1'b1;
        n = 0;
        @(negedge clk);
        while (stall_o) begin
            n++;
            if (n > WAIT_MAX) abort_run("the end of a write");
            @(negedge clk);
        end
        lat = n;
        @(posedge clk);
        d_req <= '0;
    endtask

    task automatic drop_line(input addr_t a);
        @(posedge clk);
        inv_i      <= 1'b1;
        inv_addr_i <= a;
        @(posedge clk);
        inv_i <= 1'b0;
    endtask

    task automatic instr_miss_then_hit();
        int     err0;
        int     rd0;
        int     lat;
        iword_t w;
        err0 = errors;
        rd0 = rd_count;
        fetch_instr(32'h0000_0104, w, lat);
        check_iword("i_rdata_o", w, instr_at(32'h0000_0104));
        check_count("external reads", rd_count - rd0, 1);
        fetch_instr(32'h0000_0118, w, lat);
        check_iword("i_rdata_o", w, instr_at(32'h0000_0118));
        check_count("buffer hit latency", lat, 0);
        check_count("external reads", rd_count - rd0, 1);
        finish_test("instruction miss then hit", err0);
    endtask

    task automatic replacement_order();
        int     err0;
        int     rd0;
        int     lat;
        dword_t w;
        addr_t  a [5];
        err0 = errors;
        rd0 = rd_count;
        // Five lines of set 5
        for (int k = 0; k < 5; k++) begin
            a[k] = 32'h0000_00a8 + 32'(k) * 32'h200;
            load_dword(a[k], w, lat);
            check_dword("d_rdata_o", w, data_at(a[k]));
        end
        check_count("external reads", rd_count - rd0, 5);
        // Second line still resident, served from the line RAM
        load_dword(a[1], w, lat);
        check_dword("d_rdata_o", w, data_at(a[1]));
        check_count("cache hit latency", lat, 2);
        check_count("external reads", rd_count - rd0, 5);
        // First line went out for the fifth
        load_dword(a[0], w, lat);
        check_dword("d_rdata_o", w, data_at(a[0]));
        check_count("external reads", rd_count - rd0, 6);
        finish_test("tree pseudo-LRU replacement", err0);
    endtask

    task automatic write_hit();
        int     err0;
        int     rd0;
        int     wr0;
        int     lat;
        dword_t w;
        line_t  exp_line;
        err0 = errors;
        load_dword(32'h0000_1060, w, lat);
        rd0 = rd_count;
        wr0 = wr_count;
        exp_line = mem_line[line_idx(32'h0000_1070)];
        exp_line[64*2 +: 64] = 64'h0123_4567_89ab_cdef;
        store_dword(32'h0000_1070, 64'h0123_4567_89ab_cdef, lat);
        // Request cycle in READY plus the single WRITE cycle
        check_count("stall_o cycles", lat, 2);
        check_count("external writes", wr_count - wr0, 1);
        check_line("mem_req_o.wline", last_wline, exp_line);
        load_dword(32'h0000_1070, w, lat);
        check_dword("d_rdata_o", w, 64'h0123_4567_89ab_cdef);
        check_count("external reads", rd_count - rd0, 0);
        finish_test("write-through hit", err0);
    endtask

    task automatic write_miss_alloc();
        int     err0;
        int     rd0;
        int     wr0;
        int     lat;
        dword_t w;
        dword_t nb;
        line_t  exp_line;
        err0 = errors;
        rd0 = rd_count;
        wr0 = wr_count;
        exp_line = mem_line[line_idx(32'h0000_2148)];
        exp_line[64*1 +: 64] = 64'hfeed_0000_beef_5a5a;
        nb = data_at(32'h0000_2158);
        store_dword(32'h0000_2148, 64'hfeed_0000_beef_5a5a, lat);
        check_count("external reads", rd_count - rd0, 1);
        check_count("external writes", wr_count - wr0, 1);
        check_line("mem_req_o.wline", last_wline, exp_line);
        load_dword(32'h0000_2158, w, lat);
        check_dword("d_rdata_o", w, nb);
        check_count("external reads", rd_count - rd0, 1);
        finish_test("write miss allocate", err0);
    endtask

    task automatic invalidate_then_read();
        int     err0;
        int     rd0;
        int     lat;
        dword_t w;
        err0 = errors;
        load_dword(32'h0000_3180, w, lat);
        rd0 = rd_count;
        drop_line(32'h0000_3180);
        load_dword(32'h0000_3188, w, lat);
        check_dword("d_rdata_o", w, data_at(32'h0000_3188));
        check_count("external reads", rd_count - rd0, 1);
        finish_test("invalidate", err0);
    endtask

    task automatic both_ports();
        int     err0;
        int     rd0;
        int     n;
        logic   i_done;
        logic   d_done;
        iword_t iw;
        dword_t dw;
        err0 = errors;
        rd0 = rd_count;
        i_done = 1'b0;
        d_done = 1'b0;
        n = 0;
        @(posedge clk);
        i_req.addr <= 32'h0000_41e4;
        i_req.rd   <= 1'b1;
        d_req.addr <= 32'h0000_5020;
        d_req.rd   <= 1'b1;
        while (!(i_done && d_done)) begin
            @(negedge clk);
            if (i_dv_o && !i_done) begin
                i_done = 1'b1;
                iw = i_rdata;
            end
            if (d_dv_o && !d_done) begin
                d_done = 1'b1;
                dw = d_rdata;
            end
            n++;
            if (n > WAIT_MAX) abort_run("data valid on both ports");
        end
        @(posedge clk);
        i_req <= '0;
        d_req <= '0;
        check_iword("i_rdata_o", iw, instr_at(32'h0000_41e4));
        check_dword("d_rdata_o", dw, data_at(32'h0000_5020));
        check_count("external reads", rd_count - rd0, 2);
        finish_test("both ports together", err0);
    endtask

    initial begin
        rst_n      = 1'b0;
        i_req      = '0;
        d_req      = '0;
        inv_i      = 1'b0;
        inv_addr_i = '0;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < 8; w++) begin
                mem_line[l][32*w +: 32] = $random(seed);
            end
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        instr_miss_then_hit();
        replacement_order();
        write_hit();
        write_miss_alloc();
        invalidate_then_read();
        both_ports();
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hmem_cfg_pkg.sv
hmem_if_pkg.sv
hmem_tag_store.sv
hmem_plru.sv
hmem_data_store.sv
hmem_line_buf.sv
hmem_ctrl.sv
hmem_top.sv
hmem_props.sv
tb_hmem.sv
